// File: src/usb_rx_config.svh
`ifndef USB_RX_CONFIG_SVH
`define USB_RX_CONFIG_SVH

// Full-speed line oversampling
`define USB_RX_CLKS_PER_BIT 8

// Ones in a row before a stuffed zero
`define USB_RX_STUFF_LIMIT 6

// Receive FIFO size in bytes
`define USB_RX_FIFO_DEPTH 16

// KJKJKJKK after NRZI decode and LSB-first assembly
`define USB_RX_SYNC_BYTE 8'h80

`define USB_RX_EOP_BITS 2

`endif

// File: src/usb_rx_pkg.sv
`default_nettype none

package usb_rx_pkg;

	typedef logic [7:0] usb_byte_t;
	// Fill level, 0 up to the full depth
	typedef logic [4:0] fifo_count_t;
	typedef logic [3:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t AXIL_OKAY = 2'd0;
	localparam axil_resp_t AXIL_SLVERR = 2'd2;

	typedef struct packed {
		logic dp;
		logic dm;
	} line_t;

	// Synchronized line events
	typedef struct packed {
		logic dp_edge;
		logic level;
		logic se0;
	} line_evt_t;

	// One decoded bit slot, stuffed bits never appear as valid
	typedef struct packed {
		logic valid;
		logic value;
		logic stuff_err;
		logic eop;
	} bit_evt_t;

	typedef struct packed {
		logic done;
		logic error;
		logic overflow;
		fifo_count_t count;
	} rx_status_t;

	typedef struct packed {
		logic awvalid;
		axil_addr_t awaddr;
		logic wvalid;
		axil_data_t wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		axil_addr_t araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axil_resp_t bresp;
		logic arready;
		logic rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

	typedef enum logic [2:0] {IDLE, SYNC, RECEIVE, EOP_WAIT, ERROR_WAIT} rx_state_t;

endpackage

`default_nettype wire

// File: src/usb_rx_line_sync.sv
`timescale 1ns/10ps
`default_nettype none

module usb_rx_line_sync (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::line_t line,
	output usb_rx_pkg::line_evt_t evt
);
	import usb_rx_pkg::*;

	// Bus idles in J
	localparam line_t LINE_J = '{dp: 1'b1, dm: 1'b0};

	line_t meta;
	logic sync_dp;
	logic dp_prev;
	logic se0_q;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			meta <= LINE_J;
			sync_dp <= 1'b1;
			dp_prev <= 1'b1;
			se0_q <= 1'b0;
		end else begin
			meta <= line;
			sync_dp <= meta.dp;
			dp_prev <= sync_dp;
			// Taken from the first stage so it lines up with sync_dp
			se0_q <= !meta.dp && !meta.dm;
		end
	end

	assign evt = '{dp_edge: sync_dp != dp_prev, level: sync_dp, se0: se0_q};

endmodule

`default_nettype wire

// File: src/usb_rx_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_rx_timer (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::line_evt_t evt,
	input wire rx_active,
	input wire bit_valid,
	output logic shift_strobe,
	output logic byte_done
);
	localparam int PHASE_W = $clog2(`USB_RX_CLKS_PER_BIT);
	localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`USB_RX_CLKS_PER_BIT - 1);

	logic [PHASE_W-1:0] phase;
	logic restart;
	logic [2:0] bit_cnt;

	// An edge realigns the bit period, otherwise free-run
	assign restart = evt.dp_edge || (phase == PHASE_LAST);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			phase <= '0;
			shift_strobe <= 1'b0;
		end else begin
			shift_strobe <= restart;
			if (restart) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// Decoded bits within the current byte
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			bit_cnt <= '0;
		end else if (!rx_active) begin
			bit_cnt <= '0;
		end else if (bit_valid) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Same cycle as the eighth bit so the byte shifter is still aligned
	assign byte_done = rx_active && bit_valid && (bit_cnt == 3'd7);

endmodule

`default_nettype wire

// File: src/usb_rx_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_rx_decoder (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::line_evt_t evt,
	input wire shift_strobe,
	output usb_rx_pkg::bit_evt_t bits
);
	localparam int ONES_W = $clog2(`USB_RX_STUFF_LIMIT + 1);
	localparam int SE0_W = $clog2(`USB_RX_EOP_BITS + 1);
	localparam logic [ONES_W-1:0] ONES_LIMIT = ONES_W'(`USB_RX_STUFF_LIMIT);
	localparam logic [SE0_W-1:0] SE0_LIMIT = SE0_W'(`USB_RX_EOP_BITS);

	logic prev_level;
	logic active;
	logic bit_one;
	logic [ONES_W-1:0] ones;
	logic [SE0_W-1:0] se0_cnt;

	// NRZI, no change is a one
	assign bit_one = evt.level == prev_level;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			prev_level <= 1'b1;
			active <= 1'b0;
			ones <= '0;
			se0_cnt <= '0;
			bits <= '0;
		end else begin
			bits <= '0;
			if (shift_strobe) begin
				if (evt.se0) begin
					if (se0_cnt != SE0_LIMIT) begin
						se0_cnt <= se0_cnt + 1'b1;
					end
				end else if (se0_cnt == SE0_LIMIT) begin
					// SE0 run followed by J
					bits.eop <= 1'b1;
					active <= 1'b0;
					ones <= '0;
					se0_cnt <= '0;
					prev_level <= evt.level;
				end else begin
					se0_cnt <= '0;
					prev_level <= evt.level;
					if (!active) begin
						// Idle J reads as ones, the first K starts the packet
						if (!bit_one) begin
							active <= 1'b1;
							bits.valid <= 1'b1;
							ones <= '0;
						end
					end else if (ones == ONES_LIMIT) begin
						// Stuffed slot, a zero is dropped
						ones <= '0;
						bits.stuff_err <= bit_one;
					end else begin
						bits.valid <= 1'b1;
						bits.value <= bit_one;
						ones <= bit_one ? ones + 1'b1 : '0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/usb_rx_byte_shift.sv
`timescale 1ns/10ps
`default_nettype none

module usb_rx_byte_shift (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::bit_evt_t bits,
	output usb_rx_pkg::usb_byte_t rx_byte
);
	import usb_rx_pkg::*;

	usb_byte_t shreg;

	// New bit enters at the top, first bit ends up in bit 0
	assign rx_byte = {bits.value, shreg[7:1]};

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			shreg <= '0;
		end else if (bits.valid) begin
			shreg <= rx_byte;
		end
	end

	// rx_byte only means something while the completing bit is valid

endmodule

`default_nettype wire

// File: src/usb_rx_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_rx_control (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::bit_evt_t bits,
	input wire byte_done,
	input wire usb_rx_pkg::usb_byte_t rx_byte,
	input wire clear_flags,
	output logic rx_active,
	output logic wr_en,
	output usb_rx_pkg::usb_byte_t wr_byte,
	output logic done,
	output logic error
);
	import usb_rx_pkg::*;

	rx_state_t state;

	// First bit of the packet is counted while still in IDLE
	assign rx_active = (state == SYNC) || (state == RECEIVE) || (state == EOP_WAIT) ||
		(state == IDLE && bits.valid);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			wr_en <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (clear_flags) begin
				done <= 1'b0;
				error <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (bits.valid) begin
						state <= SYNC;
					end
				end
				SYNC: begin
					if (bits.eop) begin
						error <= 1'b1;
						state <= IDLE;
					end else if (bits.stuff_err) begin
						error <= 1'b1;
						state <= ERROR_WAIT;
					end else if (byte_done) begin
						if (rx_byte == `USB_RX_SYNC_BYTE) begin
							state <= EOP_WAIT;
						end else begin
							error <= 1'b1;
							state <= ERROR_WAIT;
						end
					end
				end
				RECEIVE: begin
					// EOP here is inside a byte
					if (bits.eop) begin
						error <= 1'b1;
						state <= IDLE;
					end else if (bits.stuff_err) begin
						error <= 1'b1;
						state <= ERROR_WAIT;
					end else if (byte_done) begin
						wr_en <= 1'b1;
						state <= EOP_WAIT;
					end
				end
				EOP_WAIT: begin
					// Byte boundary, either EOP or the next byte
					if (bits.eop) begin
						done <= 1'b1;
						state <= IDLE;
					end else if (bits.stuff_err) begin
						error <= 1'b1;
						state <= ERROR_WAIT;
					end else if (bits.valid) begin
						state <= RECEIVE;
					end
				end
				ERROR_WAIT: begin
					if (bits.eop) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RECEIVE && byte_done) begin
			wr_byte <= rx_byte;
		end
	end

endmodule

`default_nettype wire

// File: src/usb_rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_rx_fifo (
	input wire clk,
	input wire n_rst,
	input wire wr_en,
	input wire usb_rx_pkg::usb_byte_t wr_byte,
	input wire pop,
	input wire flush,
	input wire clear_flags,
	output usb_rx_pkg::usb_byte_t head,
	output usb_rx_pkg::fifo_count_t count,
	output logic overflow
);
	import usb_rx_pkg::*;

	localparam int PTR_W = $clog2(`USB_RX_FIFO_DEPTH);
	localparam fifo_count_t FULL_COUNT = fifo_count_t'(`USB_RX_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`USB_RX_FIFO_DEPTH - 1);

	usb_byte_t mem [`USB_RX_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_write;
	logic do_pop;

	// Line cannot stall, a byte into a full FIFO is lost
	assign do_write = wr_en && (count != FULL_COUNT);
	assign do_pop = pop && (count != '0);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wr_byte;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (flush) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end else begin
				if (do_write) begin
					wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
				end
				if (do_pop) begin
					rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
				end
				if (do_write && !do_pop) begin
					count <= count + 1'b1;
				end else if (do_pop && !do_write) begin
					count <= count - 1'b1;
				end
			end
			if (clear_flags) begin
				overflow <= 1'b0;
			end
			if (wr_en && !do_write) begin
				overflow <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/usb_rx_axil_regs.sv
`timescale 1ns/10ps
`default_nettype none

module usb_rx_axil_regs (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::axil_req_t req,
	output usb_rx_pkg::axil_rsp_t rsp,
	input wire usb_rx_pkg::rx_status_t status,
	input wire usb_rx_pkg::usb_byte_t head,
	output logic pop,
	output logic flush,
	output logic clear_flags
);
	import usb_rx_pkg::*;

	localparam axil_addr_t ADDR_STATUS = 4'h0;
	localparam axil_addr_t ADDR_DATA = 4'h4;
	localparam axil_addr_t ADDR_CONTROL = 4'h8;

	// awready and wready always move together
	logic wr_ready;
	logic bvalid_q;
	axil_resp_t bresp_q;
	logic arready_q;
	logic rvalid_q;
	axil_resp_t rresp_q;
	axil_data_t rdata_q;
	axil_data_t status_word;
	logic empty;
	logic wr_fire;
	logic rd_fire;

	assign empty = status.count == '0;
	assign status_word = {19'b0, status.count, 5'b0, status.overflow, status.error, status.done};
	assign wr_fire = wr_ready && req.awvalid && req.wvalid;
	assign rd_fire = arready_q && req.arvalid;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ready <= 1'b0;
			bvalid_q <= 1'b0;
			bresp_q <= AXIL_OKAY;
			flush <= 1'b0;
			clear_flags <= 1'b0;
		end else begin
			flush <= 1'b0;
			clear_flags <= 1'b0;
			if (wr_fire) begin
				wr_ready <= 1'b0;
				bvalid_q <= 1'b1;
				bresp_q <= (req.awaddr == ADDR_CONTROL) ? AXIL_OKAY : AXIL_SLVERR;
				if (req.awaddr == ADDR_CONTROL && req.wstrb[0]) begin
					clear_flags <= req.wdata[0];
					flush <= req.wdata[1];
				end
			end else if (!wr_ready && !bvalid_q && req.awvalid && req.wvalid) begin
				wr_ready <= 1'b1;
			end
			if (bvalid_q && req.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			rresp_q <= AXIL_OKAY;
			rdata_q <= '0;
			pop <= 1'b0;
		end else begin
			pop <= 1'b0;
			if (rd_fire) begin
				arready_q <= 1'b0;
				rvalid_q <= 1'b1;
				rresp_q <= AXIL_OKAY;
				case (req.araddr)
					ADDR_STATUS: rdata_q <= status_word;
					ADDR_DATA: begin
						// Head is captured before the pop takes effect
						rdata_q <= empty ? '0 : axil_data_t'(head);
						pop <= !empty;
					end
					default: begin
						rdata_q <= '0;
						rresp_q <= AXIL_SLVERR;
					end
				endcase
			end else if (!arready_q && !rvalid_q && req.arvalid) begin
				arready_q <= 1'b1;
			end
			if (rvalid_q && req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	assign rsp = '{awready: wr_ready, wready: wr_ready, bvalid: bvalid_q, bresp: bresp_q,
		arready: arready_q, rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

endmodule

`default_nettype wire

// File: src/usb_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module usb_rx_top (
	input wire clk,
	input wire n_rst,
	input wire usb_rx_pkg::line_t line,
	input wire usb_rx_pkg::axil_req_t axil_req,
	output usb_rx_pkg::axil_rsp_t axil_rsp
);
	import usb_rx_pkg::*;

	line_evt_t line_evt;
	bit_evt_t bit_evt;
	logic shift_strobe;
	logic byte_done;
	logic rx_active;
	logic wr_en;
	logic pop;
	logic flush;
	logic clear_flags;
	logic done;
	logic error;
	logic overflow;
	usb_byte_t rx_byte;
	usb_byte_t wr_byte;
	usb_byte_t head;
	fifo_count_t count;
	rx_status_t status;

	assign status = '{done: done, error: error, overflow: overflow, count: count};

	usb_rx_line_sync u_line_sync (.clk(clk), .n_rst(n_rst), .line(line), .evt(line_evt));

	usb_rx_timer u_timer (.clk(clk), .n_rst(n_rst), .evt(line_evt), .rx_active(rx_active),
		.bit_valid(bit_evt.valid), .shift_strobe(shift_strobe), .byte_done(byte_done));

	usb_rx_decoder u_decoder (.clk(clk), .n_rst(n_rst), .evt(line_evt),
		.shift_strobe(shift_strobe), .bits(bit_evt));

	usb_rx_byte_shift u_byte_shift (.clk(clk), .n_rst(n_rst), .bits(bit_evt), .rx_byte(rx_byte));

	usb_rx_control u_control (.clk(clk), .n_rst(n_rst), .bits(bit_evt), .byte_done(byte_done),
		.rx_byte(rx_byte), .clear_flags(clear_flags), .rx_active(rx_active), .wr_en(wr_en),
		.wr_byte(wr_byte), .done(done), .error(error));

	usb_rx_fifo u_fifo (.clk(clk), .n_rst(n_rst), .wr_en(wr_en), .wr_byte(wr_byte), .pop(pop),
		.flush(flush), .clear_flags(clear_flags), .head(head), .count(count),
		.overflow(overflow));

	usb_rx_axil_regs u_regs (.clk(clk), .n_rst(n_rst), .req(axil_req), .rsp(axil_rsp),
		.status(status), .head(head), .pop(pop), .flush(flush), .clear_flags(clear_flags));

endmodule

`default_nettype wire

// File: tb/tb_usb_rx_line_model.sv
`default_nettype none

`include "usb_rx_config.svh"

package tb_usb_rx_line_model;
	import usb_rx_pkg::*;

	localparam int BIT_CLKS = `USB_RX_CLKS_PER_BIT;
	localparam int MAX_BYTES = 12;
	localparam int MAX_LINE_BITS = 160;
	localparam int MAX_PACKETS = 4;
	// J held after EOP so the receiver is idle before the next packet
	localparam int IDLE_BITS = 4;
	localparam usb_byte_t SYNC_PATTERN = `USB_RX_SYNC_BYTE;

	localparam axil_addr_t STATUS_ADDR = 4'h0;
	localparam axil_addr_t DATA_ADDR = 4'h4;
	localparam axil_addr_t CONTROL_ADDR = 4'h8;

	localparam line_t LINE_J = '{dp: 1'b1, dm: 1'b0};
	localparam line_t LINE_K = '{dp: 1'b0, dm: 1'b1};
	localparam line_t LINE_SE0 = '{dp: 1'b0, dm: 1'b0};

	typedef usb_byte_t byte_list_t [MAX_BYTES];
	typedef line_t line_seq_t [MAX_LINE_BITS];
	typedef int count_list_t [MAX_PACKETS];
	typedef bit flag_list_t [MAX_PACKETS];

	// Bytes LSB first, stuffed, NRZI coded, then EOP and idle J
	function automatic int encode_packet(input byte_list_t bytes, input int nbits,
		input bit stuff_on, output line_seq_t seq);
		line_t level;
		logic data_bit;
		logic [2:0] bit_idx;
		int len;
		int ones;
		int i;
		level = LINE_J;
		len = 0;
		ones = 0;
		for (i = 0; i < nbits; i++) begin
			bit_idx = 3'(i % 8);
			data_bit = bytes[i / 8][bit_idx];
			// A zero toggles the line
			if (!data_bit) begin
				level = (level == LINE_J) ? LINE_K : LINE_J;
			end
			seq[len] = level;
			len++;
			ones = data_bit ? ones + 1 : 0;
			if (stuff_on && ones == `USB_RX_STUFF_LIMIT) begin
				level = (level == LINE_J) ? LINE_K : LINE_J;
				seq[len] = level;
				len++;
				ones = 0;
			end
		end
		for (i = 0; i < `USB_RX_EOP_BITS; i++) begin
			seq[len] = LINE_SE0;
			len++;
		end
		for (i = 0; i < IDLE_BITS; i++) begin
			seq[len] = LINE_J;
			len++;
		end
		return len;
	endfunction

	// STATUS word after a list of packets, held is what the FIFO had before
	function automatic axil_data_t expected_status(input int held, input count_list_t stored,
		input flag_list_t clean, input int npkts);
		axil_data_t word;
		int total;
		int i;
		total = held;
		word = '0;
		for (i = 0; i < npkts; i++) begin
			total += stored[i];
			if (clean[i]) begin
				word[0] = 1'b1;
			end else begin
				word[1] = 1'b1;
			end
		end
		// Bytes beyond the FIFO depth are lost
		word[2] = total > `USB_RX_FIFO_DEPTH;
		word[12:8] = 5'((total > `USB_RX_FIFO_DEPTH) ? `USB_RX_FIFO_DEPTH : total);
		return word;
	endfunction

	function automatic axil_req_t read_request(input axil_addr_t addr);
		axil_req_t req;
		req = '0;
		req.arvalid = 1'b1;
		req.araddr = addr;
		req.rready = 1'b1;
		return req;
	endfunction

	function automatic axil_req_t write_request(input axil_addr_t addr, input axil_data_t data);
		axil_req_t req;
		req = '0;
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		req.wstrb = 4'hf;
		req.bready = 1'b1;
		return req;
	endfunction

endpackage

`default_nettype wire

// File: tb/tb_usb_rx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_usb_rx;
	import usb_rx_pkg::*;
	import tb_usb_rx_line_model::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int POLL_LIMIT = 20;
	// Watchdog budget
	localparam int PACKETS_SENT = 7;
	localparam int AXI_ACCESSES = 80;
	localparam int AXI_MARGIN_NS = 40 * CLK_PERIOD;
	localparam int TIMEOUT_NS = (RESET_CYCLES + PACKETS_SENT * MAX_LINE_BITS * BIT_CLKS) *
		CLK_PERIOD + AXI_ACCESSES * AXI_MARGIN_NS;

	logic clk;
	logic n_rst;
	line_t line;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	int seed;

	usb_rx_top DUT (.clk(clk), .n_rst(n_rst), .line(line), .axil_req(axil_req),
		.axil_rsp(axil_rsp));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		stop_with_failure("Timeout, the tests did not finish in the expected time");
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input axil_data_t expected,
		input axil_data_t actual);
		assert (actual == expected) else begin
			stop_with_failure($sformatf("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual));
		end
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
		output axil_resp_t resp);
		@(posedge clk);
		axil_req <= read_request(addr);
		@(posedge clk);
		while (!axil_rsp.arready) @(posedge clk);
		axil_req.arvalid <= 1'b0;
		@(posedge clk);
		while (!axil_rsp.rvalid) @(posedge clk);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready <= 1'b0;
	endtask

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
		output axil_resp_t resp);
		@(posedge clk);
		axil_req <= write_request(addr, data);
		@(posedge clk);
		while (!axil_rsp.awready) @(posedge clk);
		// Address and data are accepted in the same cycle
		check_value("wready", 32'h1, 32'(axil_rsp.wready));
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		@(posedge clk);
		while (!axil_rsp.bvalid) @(posedge clk);
		resp = axil_rsp.bresp;
		axil_req.bready <= 1'b0;
	endtask

	task automatic read_expect(input axil_addr_t addr, input axil_data_t expected,
		input string name);
		axil_data_t data;
		axil_resp_t resp;
		axil_read(addr, data, resp);
		check_value({name, " rresp"}, 32'(AXIL_OKAY), 32'(resp));
		check_value(name, expected, data);
	endtask

	task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
		input axil_resp_t expected_resp, input string name);
		axil_resp_t resp;
		axil_write(addr, data, resp);
		check_value(name, 32'(expected_resp), 32'(resp));
	endtask

	task automatic clear_status_flags();
		write_expect(CONTROL_ADDR, 32'h1, AXIL_OKAY, "CONTROL bresp");
	endtask

	task automatic random_payload(output byte_list_t bytes);
		int i;
		for (i = 0; i < MAX_BYTES; i++) begin
			bytes[i] = 8'($random(seed));
		end
		bytes[0] = SYNC_PATTERN;
	endtask

	task automatic send_packet(input byte_list_t bytes, input int nbits, input bit stuff_on);
		line_seq_t seq;
		int len;
		int i;
		len = encode_packet(bytes, nbits, stuff_on, seq);
		for (i = 0; i < len; i++) begin
			@(posedge clk);
			line <= seq[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	// Flags are cleared before each packet, so done or error marks its end
	task automatic wait_packet_end();
		axil_data_t data;
		axil_resp_t resp;
		int polls;
		polls = 0;
		axil_read(STATUS_ADDR, data, resp);
		while (data[1:0] == 2'b00 && polls < POLL_LIMIT) begin
			polls++;
			axil_read(STATUS_ADDR, data, resp);
		end
		if (data[1:0] == 2'b00) begin
			stop_with_failure("Receiver never flagged the end of the packet in STATUS");
		end
	endtask

	initial begin
		byte_list_t pkt;
		byte_list_t first;
		count_list_t stored;
		flag_list_t clean;
		int i;
		seed = 32'h9eda8ebe;
		line = LINE_J;
		axil_req = '0;
		n_rst = 1'b0;
		stored = '{default: 0};
		clean = '{default: 1'b0};
		repeat (RESET_CYCLES) @(posedge clk);
		n_rst <= 1'b1;

		read_expect(STATUS_ADDR, 32'h0, "STATUS after reset");
		read_expect(DATA_ADDR, 32'h0, "DATA after reset");

		// Runs of 0xFF force stuffed bits
		random_payload(pkt);
		pkt[2] = 8'hff;
		pkt[3] = 8'hff;
		pkt[6] = 8'hff;
		send_packet(pkt, 9 * 8, 1'b1);
		wait_packet_end();
		stored[0] = 8;
		clean[0] = 1'b1;
		read_expect(STATUS_ADDR, expected_status(0, stored, clean, 1), "STATUS clean packet");
		for (i = 1; i <= 8; i++) begin
			read_expect(DATA_ADDR, 32'(pkt[i]), "DATA clean packet");
		end

		// Sync byte that still starts with a K
		clear_status_flags();
		random_payload(pkt);
		pkt[0] = 8'hc0;
		send_packet(pkt, 4 * 8, 1'b1);
		wait_packet_end();
		stored[0] = 0;
		clean[0] = 1'b0;
		read_expect(STATUS_ADDR, expected_status(0, stored, clean, 1), "STATUS bad sync");

		// Seven ones in a row with no stuffed zero
		clear_status_flags();
		pkt[0] = SYNC_PATTERN;
		pkt[1] = 8'hff;
		pkt[2] = 8'hff;
		send_packet(pkt, 3 * 8, 1'b0);
		wait_packet_end();
		read_expect(STATUS_ADDR, expected_status(0, stored, clean, 1), "STATUS stuff error");

		// EOP three bits into the second data byte
		clear_status_flags();
		random_payload(pkt);
		pkt[2] = 8'h05;
		send_packet(pkt, 2 * 8 + 3, 1'b1);
		wait_packet_end();
		stored[0] = 1;
		read_expect(STATUS_ADDR, expected_status(0, stored, clean, 1), "STATUS early EOP");
		read_expect(DATA_ADDR, 32'(pkt[1]), "DATA early EOP");

		// Twenty bytes into a sixteen byte FIFO
		clear_status_flags();
		random_payload(first);
		send_packet(first, 11 * 8, 1'b1);
		wait_packet_end();
		clear_status_flags();
		random_payload(pkt);
		send_packet(pkt, 11 * 8, 1'b1);
		wait_packet_end();
		stored[0] = 10;
		clean[0] = 1'b1;
		read_expect(STATUS_ADDR, expected_status(10, stored, clean, 1), "STATUS overflow");
		for (i = 1; i <= 10; i++) begin
			read_expect(DATA_ADDR, 32'(first[i]), "DATA overflow first packet");
		end
		for (i = 1; i <= 6; i++) begin
			read_expect(DATA_ADDR, 32'(pkt[i]), "DATA overflow second packet");
		end

		// Leave bytes behind, then clear and flush together
		clear_status_flags();
		random_payload(pkt);
		send_packet(pkt, 3 * 8, 1'b1);
		wait_packet_end();
		stored[0] = 2;
		read_expect(STATUS_ADDR, expected_status(0, stored, clean, 1), "STATUS short packet");
		write_expect(CONTROL_ADDR, 32'h3, AXIL_OKAY, "CONTROL bresp");
		read_expect(STATUS_ADDR, 32'h0, "STATUS after flush");
		read_expect(DATA_ADDR, 32'h0, "DATA after flush");
		write_expect(DATA_ADDR, 32'h1, AXIL_SLVERR, "DATA write bresp");

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/usb_rx_pkg.sv
src/usb_rx_line_sync.sv
src/usb_rx_timer.sv
src/usb_rx_decoder.sv
src/usb_rx_byte_shift.sv
src/usb_rx_control.sv
src/usb_rx_fifo.sv
src/usb_rx_axil_regs.sv
src/usb_rx_top.sv
tb/tb_usb_rx_line_model.sv
tb/tb_usb_rx.sv

// File: run.sh
#!/bin/sh
# Build and run the USB receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_usb_rx -o sim_usb_rx || exit 1

out=$(./obj_dir/sim_usb_rx)
echo "$out"

echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1
